// File: rtl/axi_mini_defs.svh
`ifndef AXI_MINI_DEFS_SVH
`define AXI_MINI_DEFS_SVH

// Width of the AXI transaction ID.
`define AXI_ID_W 4

// Width of the AXI byte address.
`define AXI_ADDR_W 16

// Width of one data beat, which is also one memory word.
`define AXI_DATA_W 32

// Write bursts that may be admitted downstream before their last W beat has passed.
`define AXI_MAX_WRITE_TXNS 2

// Number of words in the shared memory.
`define MEM_DEPTH 256

// Width of the word index, taken from byte address bits [9:2].
`define MEM_ADDR_W 8

`endif

// File: rtl/axi_mini_pkg.sv
`default_nettype none

`include "axi_mini_defs.svh"

package axi_mini_pkg;

  // Response codes that this subsystem returns on B and R.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // Atomic operation kind, as coded in atop[5:4].
  typedef enum logic [1:0] {
    ATOP_NONE          = 2'b00,
    ATOP_ATOMICSTORE   = 2'b01,
    ATOP_ATOMICLOAD    = 2'b10,
    ATOP_ATOMICSWAP_CMP = 2'b11
  } atop_kind_e;

  typedef logic [`AXI_ID_W-1:0]   id_t;
  typedef logic [`AXI_ADDR_W-1:0] addr_t;
  typedef logic [`AXI_DATA_W-1:0] data_t;
  // Burst length minus one, as on the AXI len field.
  typedef logic [7:0]             len_t;

  typedef struct packed {
    id_t        id;
    addr_t      addr;
    len_t       len;
    logic [5:0] atop;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_e resp;
    logic  last;
  } r_chan_t;

endpackage

`default_nettype wire

// File: rtl/mem_pkg.sv
`default_nettype none

`include "axi_mini_defs.svh"

package mem_pkg;

  // One memory word.
  typedef logic [`AXI_DATA_W-1:0] word_t;

  // A request from one client to the shared SRAM.
  typedef struct packed {
    logic                   we;
    logic [`MEM_ADDR_W-1:0] idx;
    word_t                  wdata;
  } mem_req_t;

  // States of the write side of the ATOP filter.
  typedef enum logic [2:0] {
    W_FEEDTHROUGH,
    BLOCK_AW,
    ABSORB_W,
    INJECT_B,
    WAIT_R
  } filt_w_state_e;

  // States of the read side of the ATOP filter.
  typedef enum logic {
    R_FEEDTHROUGH,
    INJECT_R
  } filt_r_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_REQ,
    RD_DATA
  } rd_state_e;

  // The client that the arbiter served last.
  typedef enum logic {
    GRANT_WR,
    GRANT_RD
  } grant_e;

endpackage

`default_nettype wire

// File: rtl/axi_chan_if.sv
`timescale 1ns/1ps
`default_nettype none

// All five channels of the reduced AXI4 subset between one master and its slaves.
interface axi_chan_if;

  logic                   aw_valid;
  logic                   aw_ready;
  axi_mini_pkg::aw_chan_t aw;
  logic                   w_valid;
  logic                   w_ready;
  axi_mini_pkg::w_chan_t  w;
  logic                   b_valid;
  logic                   b_ready;
  axi_mini_pkg::b_chan_t  b;
  logic                   ar_valid;
  logic                   ar_ready;
  axi_mini_pkg::ar_chan_t ar;
  logic                   r_valid;
  logic                   r_ready;
  axi_mini_pkg::r_chan_t  r;

  // The master drives requests and the ready of both response channels.
  modport mst (
    output aw_valid, aw, w_valid, w, b_ready, ar_valid, ar, r_ready,
    input  aw_ready, w_ready, b_valid, b, ar_ready, r_valid, r
  );

  // Several slaves may share this side as long as each drives only its own channels.
  modport slv (
    input  aw_valid, aw, w_valid, w, b_ready, ar_valid, ar, r_ready,
    output aw_ready, w_ready, b_valid, b, ar_ready, r_valid, r
  );

endinterface

`default_nettype wire

// File: rtl/mem_port_if.sv
`timescale 1ns/1ps
`default_nettype none

// One client port of the shared SRAM.
interface mem_port_if;

  logic              req;
  mem_pkg::mem_req_t cmd;
  logic              gnt;
  // Read data, valid exactly one cycle after a granted read.
  mem_pkg::word_t    rdata;

  modport client (output req, cmd, input gnt, rdata);
  modport server (input req, cmd, output gnt, rdata);

endinterface

`default_nettype wire

// File: rtl/axi_atop_filter.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mini_defs.svh"

// Removes atomic writes from the stream toward the memory and answers them itself.
// Each atomic burst gets a SLVERR B, and all kinds except atomic store also get a
// SLVERR R burst of len+1 beats.
module axi_atop_filter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   slv_aw_valid_i,
  input  axi_mini_pkg::aw_chan_t slv_aw_i,
  output logic                   slv_aw_ready_o,
  input  logic                   slv_w_valid_i,
  input  axi_mini_pkg::w_chan_t  slv_w_i,
  output logic                   slv_w_ready_o,
  output logic                   slv_b_valid_o,
  output axi_mini_pkg::b_chan_t  slv_b_o,
  input  logic                   slv_b_ready_i,
  input  logic                   slv_ar_valid_i,
  input  axi_mini_pkg::ar_chan_t slv_ar_i,
  output logic                   slv_ar_ready_o,
  output logic                   slv_r_valid_o,
  output axi_mini_pkg::r_chan_t  slv_r_o,
  input  logic                   slv_r_ready_i,
  axi_chan_if.mst                bus_o
);

  typedef logic [$clog2(`AXI_MAX_WRITE_TXNS+1)-1:0] cnt_t;

  mem_pkg::filt_w_state_e w_state_d, w_state_q;
  mem_pkg::filt_r_state_e r_state_d, r_state_q;
  cnt_t                   w_cnt_d, w_cnt_q;
  axi_mini_pkg::id_t      id_d, id_q;
  // One-entry command register with the beats still owed on the error R burst.
  axi_mini_pkg::len_t     r_beats_d, r_beats_q;
  logic                   r_push;
  logic                   r_done;
  logic                   is_atop;
  axi_mini_pkg::aw_chan_t aw_out;
  logic                   aw_valid_out;
  logic                   w_valid_out;
  logic                   b_ready_out;
  logic                   r_ready_out;
  axi_mini_pkg::r_chan_t  r_out;

  assign is_atop = slv_aw_valid_i &&
                   (slv_aw_i.atop[5:4] != axi_mini_pkg::ATOP_NONE);

  // Write side. AW passes while the outstanding limit allows it, and W passes only
  // once its AW is downstream, because the atop of the AW decides the fate of W.
  always_comb begin
    aw_out         = slv_aw_i;
    aw_out.atop    = '0;
    aw_valid_out   = 1'b0;
    slv_aw_ready_o = 1'b0;
    w_valid_out    = 1'b0;
    slv_w_ready_o  = 1'b0;
    b_ready_out    = slv_b_ready_i;
    slv_b_valid_o  = bus_o.b_valid;
    slv_b_o        = bus_o.b;
    id_d           = id_q;
    r_push         = 1'b0;
    w_state_d      = w_state_q;

    unique case (w_state_q)
      mem_pkg::W_FEEDTHROUGH: begin
        if (w_cnt_q < `AXI_MAX_WRITE_TXNS) begin
          aw_valid_out   = slv_aw_valid_i;
          slv_aw_ready_o = bus_o.aw_ready;
        end
        if (w_cnt_q != '0) begin
          w_valid_out   = slv_w_valid_i;
          slv_w_ready_o = bus_o.w_ready;
        end
        if (is_atop) begin
          // The atomic AW is taken here and never reaches the memory.
          aw_valid_out   = 1'b0;
          slv_aw_ready_o = 1'b1;
          id_d           = slv_aw_i.id;
          r_push         = (slv_aw_i.atop[5:4] != axi_mini_pkg::ATOP_ATOMICSTORE);
          if (w_cnt_q != '0) begin
            // Earlier bursts still own the W channel.
            w_state_d = mem_pkg::BLOCK_AW;
          end else begin
            w_valid_out   = 1'b0;
            slv_w_ready_o = 1'b1;
            w_state_d = (slv_w_valid_i && slv_w_i.last) ? mem_pkg::INJECT_B
                                                        : mem_pkg::ABSORB_W;
          end
        end
      end
      mem_pkg::BLOCK_AW: begin
        if (w_cnt_q != '0) begin
          w_valid_out   = slv_w_valid_i;
          slv_w_ready_o = bus_o.w_ready;
        end else begin
          slv_w_ready_o = 1'b1;
          w_state_d = (slv_w_valid_i && slv_w_i.last) ? mem_pkg::INJECT_B
                                                      : mem_pkg::ABSORB_W;
        end
      end
      mem_pkg::ABSORB_W: begin
        // Beats of the atomic burst are dropped, one per cycle.
        slv_w_ready_o = 1'b1;
        if (slv_w_valid_i && slv_w_i.last) begin
          w_state_d = mem_pkg::INJECT_B;
        end
      end
      mem_pkg::INJECT_B: begin
        // Downstream B waits while the error response goes out.
        b_ready_out   = 1'b0;
        slv_b_valid_o = 1'b1;
        slv_b_o.id    = id_q;
        slv_b_o.resp  = axi_mini_pkg::RESP_SLVERR;
        if (slv_b_ready_i) begin
          w_state_d = (r_state_q == mem_pkg::INJECT_R && !r_done) ? mem_pkg::WAIT_R
                                                                 : mem_pkg::W_FEEDTHROUGH;
        end
      end
      mem_pkg::WAIT_R: begin
        if (r_state_q == mem_pkg::R_FEEDTHROUGH) begin
          w_state_d = mem_pkg::W_FEEDTHROUGH;
        end
      end
      default: w_state_d = mem_pkg::W_FEEDTHROUGH;
    endcase
  end

  // Read side. AR always passes. An error burst is injected at once, since its ID is
  // the only one of its kind in flight and needs no ordering against other reads.
  always_comb begin
    slv_ar_ready_o = bus_o.ar_ready;
    slv_r_valid_o  = bus_o.r_valid;
    slv_r_o        = bus_o.r;
    r_ready_out    = slv_r_ready_i;
    r_out          = '0;
    r_beats_d      = r_beats_q;
    r_done         = 1'b0;
    r_state_d      = r_state_q;

    unique case (r_state_q)
      mem_pkg::R_FEEDTHROUGH: begin
        if (r_push) begin
          r_beats_d = slv_aw_i.len;
          r_state_d = mem_pkg::INJECT_R;
        end
      end
      mem_pkg::INJECT_R: begin
        r_ready_out   = 1'b0;
        r_out.id      = id_q;
        r_out.resp    = axi_mini_pkg::RESP_SLVERR;
        r_out.last    = (r_beats_q == '0);
        slv_r_o       = r_out;
        slv_r_valid_o = 1'b1;
        if (slv_r_ready_i) begin
          if (r_out.last) begin
            r_done    = 1'b1;
            r_state_d = mem_pkg::R_FEEDTHROUGH;
          end else begin
            r_beats_d = r_beats_q - 8'd1;
          end
        end
      end
      default: r_state_d = mem_pkg::R_FEEDTHROUGH;
    endcase
  end

  // A burst counts from its downstream AW until its last W beat has passed.
  always_comb begin
    w_cnt_d = w_cnt_q;
    if (aw_valid_out && bus_o.aw_ready) begin
      w_cnt_d = w_cnt_d + cnt_t'(1);
    end
    if (w_valid_out && bus_o.w_ready && slv_w_i.last) begin
      w_cnt_d = w_cnt_d - cnt_t'(1);
    end
  end

  assign bus_o.aw_valid = aw_valid_out;
  assign bus_o.aw       = aw_out;
  assign bus_o.w_valid  = w_valid_out;
  assign bus_o.w        = slv_w_i;
  assign bus_o.b_ready  = b_ready_out;
  assign bus_o.ar_valid = slv_ar_valid_i;
  assign bus_o.ar       = slv_ar_i;
  assign bus_o.r_ready  = r_ready_out;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_state_q <= mem_pkg::W_FEEDTHROUGH;
      r_state_q <= mem_pkg::R_FEEDTHROUGH;
      w_cnt_q   <= '0;
      id_q      <= '0;
      r_beats_q <= '0;
    end else begin
      w_state_q <= w_state_d;
      r_state_q <= r_state_d;
      w_cnt_q   <= w_cnt_d;
      id_q      <= id_d;
      r_beats_q <= r_beats_d;
    end
  end

  // No atomic request may ever reach the memory engines.
  a_no_atop_downstream : assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_o.aw_valid |-> (slv_aw_i.atop[5:4] == axi_mini_pkg::ATOP_NONE))
    else $error("atomic AW leaked to the memory side");

  // The outstanding count follows handshakes on both sides and must stay bounded.
  a_wcnt_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_cnt_q <= `AXI_MAX_WRITE_TXNS)
    else $error("outstanding write count above its limit");

endmodule

`default_nettype wire

// File: rtl/axi_mem_write.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mini_defs.svh"

// Write engine. Takes one AW burst at a time, writes each W beat into the SRAM in the
// cycle the write port is granted, and answers with B OKAY.
module axi_mem_write (
  input  logic        clk_i,
  input  logic        rst_ni,
  axi_chan_if.slv     bus_i,
  mem_port_if.client  mem_o
);

  mem_pkg::wr_state_e     state_q;
  axi_mini_pkg::id_t      id_q;
  axi_mini_pkg::len_t     len_q;
  axi_mini_pkg::len_t     beat_q;
  logic [`MEM_ADDR_W-1:0] idx_q;
  logic                   beat_done;
  logic                   last_beat;

  // Ready only follows a valid AW, so it stays low while nothing is offered.
  assign bus_i.aw_ready = (state_q == mem_pkg::WR_IDLE) && bus_i.aw_valid;

  // Each offered beat becomes one write request, and the beat is taken on the grant.
  assign mem_o.req       = (state_q == mem_pkg::WR_DATA) && bus_i.w_valid;
  assign mem_o.cmd.we    = 1'b1;
  assign mem_o.cmd.idx   = idx_q;
  assign mem_o.cmd.wdata = bus_i.w.data;
  assign bus_i.w_ready   = mem_o.gnt;

  assign beat_done = bus_i.w_valid && mem_o.gnt;
  assign last_beat = (beat_q == len_q);

  assign bus_i.b_valid = (state_q == mem_pkg::WR_RESP);
  assign bus_i.b.id    = id_q;
  assign bus_i.b.resp  = axi_mini_pkg::RESP_OKAY;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= mem_pkg::WR_IDLE;
    end else begin
      unique case (state_q)
        mem_pkg::WR_IDLE:
          if (bus_i.aw_valid) state_q <= mem_pkg::WR_DATA;
        mem_pkg::WR_DATA:
          if (beat_done && last_beat) state_q <= mem_pkg::WR_RESP;
        mem_pkg::WR_RESP:
          if (bus_i.b_ready) state_q <= mem_pkg::WR_IDLE;
        default: state_q <= mem_pkg::WR_IDLE;
      endcase
    end
  end

  // Burst fields and the running word index.
  always_ff @(posedge clk_i) begin
    if (bus_i.aw_valid && bus_i.aw_ready) begin
      id_q   <= bus_i.aw.id;
      len_q  <= bus_i.aw.len;
      idx_q  <= bus_i.aw.addr[`MEM_ADDR_W+1:2];
      beat_q <= '0;
    end else if (beat_done) begin
      idx_q  <= idx_q + 1'b1;
      beat_q <= beat_q + 8'd1;
    end
  end

  // The master marks the last beat exactly where the AW length says it ends.
  a_last_at_len : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus_i.w_valid && bus_i.w_ready) |-> (bus_i.w.last == last_beat))
    else $error("W last does not match the AW burst length");

endmodule

`default_nettype wire

// File: rtl/axi_mem_read.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mini_defs.svh"

// Read engine. Takes one AR burst at a time and reads one word per beat. Each beat
// is requested only after the previous R beat has been taken.
module axi_mem_read (
  input  logic        clk_i,
  input  logic        rst_ni,
  axi_chan_if.slv     bus_i,
  mem_port_if.client  mem_o
);

  mem_pkg::rd_state_e     state_q;
  axi_mini_pkg::id_t      id_q;
  axi_mini_pkg::len_t     len_q;
  axi_mini_pkg::len_t     beat_q;
  logic [`MEM_ADDR_W-1:0] idx_q;
  // High in the cycle right after a grant, when the SRAM output holds the new word.
  logic                   fresh_q;
  mem_pkg::word_t         hold_q;
  logic                   r_done;

  assign bus_i.ar_ready = (state_q == mem_pkg::RD_IDLE) && bus_i.ar_valid;

  assign mem_o.req       = (state_q == mem_pkg::RD_REQ);
  assign mem_o.cmd.we    = 1'b0;
  assign mem_o.cmd.idx   = idx_q;
  assign mem_o.cmd.wdata = '0;

  // The word comes straight from the SRAM on its first cycle and from the holding
  // register while the master stalls.
  assign bus_i.r_valid = (state_q == mem_pkg::RD_DATA);
  assign bus_i.r.id    = id_q;
  assign bus_i.r.data  = fresh_q ? mem_o.rdata : hold_q;
  assign bus_i.r.resp  = axi_mini_pkg::RESP_OKAY;
  assign bus_i.r.last  = (beat_q == len_q);

  assign r_done = bus_i.r_valid && bus_i.r_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= mem_pkg::RD_IDLE;
      fresh_q <= 1'b0;
    end else begin
      fresh_q <= (state_q == mem_pkg::RD_REQ) && mem_o.gnt;
      unique case (state_q)
        mem_pkg::RD_IDLE:
          if (bus_i.ar_valid) state_q <= mem_pkg::RD_REQ;
        mem_pkg::RD_REQ:
          if (mem_o.gnt) state_q <= mem_pkg::RD_DATA;
        mem_pkg::RD_DATA:
          if (r_done) state_q <= bus_i.r.last ? mem_pkg::RD_IDLE : mem_pkg::RD_REQ;
        default: state_q <= mem_pkg::RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.ar_valid && bus_i.ar_ready) begin
      id_q   <= bus_i.ar.id;
      len_q  <= bus_i.ar.len;
      idx_q  <= bus_i.ar.addr[`MEM_ADDR_W+1:2];
      beat_q <= '0;
    end else if (r_done) begin
      idx_q  <= idx_q + 1'b1;
      beat_q <= beat_q + 8'd1;
    end
    if (fresh_q) begin
      hold_q <= mem_o.rdata;
    end
  end

  // A stalled beat keeps its place and its payload until the master takes it.
  a_r_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus_i.r_valid && !bus_i.r_ready) |=> (bus_i.r_valid && $stable(bus_i.r)))
    else $error("R payload changed while stalled");

endmodule

`default_nettype wire

// File: rtl/shared_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mini_defs.svh"

// Single-ported memory shared by the write and the read engine. When both ask in the
// same cycle the client that was not served last wins, so the write client goes first
// after reset.
module shared_sram (
  input  logic        clk_i,
  input  logic        rst_ni,
  mem_port_if.server  wr_i,
  mem_port_if.server  rd_i
);

  mem_pkg::grant_e   last_q;
  mem_pkg::mem_req_t sel;
  logic              sel_valid;
  mem_pkg::word_t    rdata_q;
  mem_pkg::word_t    mem_q [`MEM_DEPTH];

  assign wr_i.gnt = wr_i.req && (!rd_i.req || last_q == mem_pkg::GRANT_RD);
  assign rd_i.gnt = rd_i.req && !wr_i.gnt;

  assign sel       = wr_i.gnt ? wr_i.cmd : rd_i.cmd;
  assign sel_valid = wr_i.gnt || rd_i.gnt;

  // Both ports see the same registered read word.
  assign wr_i.rdata = rdata_q;
  assign rd_i.rdata = rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= mem_pkg::GRANT_RD;
    end else if (wr_i.gnt) begin
      last_q <= mem_pkg::GRANT_WR;
    end else if (rd_i.gnt) begin
      last_q <= mem_pkg::GRANT_RD;
    end
  end

  // A granted write lands in its cycle, and a granted read shows its word one cycle later.
  always_ff @(posedge clk_i) begin
    if (sel_valid && sel.we) begin
      mem_q[sel.idx] <= sel.wdata;
    end else if (sel_valid) begin
      rdata_q <= mem_q[sel.idx];
    end
  end

  // A write client that loses the arbitration and keeps asking is served next cycle.
  a_wr_served : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_i.req && !wr_i.gnt) |=> (wr_i.gnt || !wr_i.req))
    else $error("write client denied twice in a row");

  // The same holds for the read client.
  a_rd_served : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rd_i.req && !rd_i.gnt) |=> (rd_i.gnt || !rd_i.req))
    else $error("read client denied twice in a row");

endmodule

`default_nettype wire

// File: rtl/atop_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

// Memory target behind an ATOP filter. The master's channels enter the filter, the
// engines share the SRAM through its two client ports.
module atop_mem_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   s_aw_valid_i,
  input  axi_mini_pkg::aw_chan_t s_aw_i,
  output logic                   s_aw_ready_o,
  input  logic                   s_w_valid_i,
  input  axi_mini_pkg::w_chan_t  s_w_i,
  output logic                   s_w_ready_o,
  output logic                   s_b_valid_o,
  output axi_mini_pkg::b_chan_t  s_b_o,
  input  logic                   s_b_ready_i,
  input  logic                   s_ar_valid_i,
  input  axi_mini_pkg::ar_chan_t s_ar_i,
  output logic                   s_ar_ready_o,
  output logic                   s_r_valid_o,
  output axi_mini_pkg::r_chan_t  s_r_o,
  input  logic                   s_r_ready_i
);

  axi_chan_if mem_bus ();
  mem_port_if wr_port ();
  mem_port_if rd_port ();

  axi_atop_filter u_filter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_valid_i (s_aw_valid_i),
    .slv_aw_i       (s_aw_i),
    .slv_aw_ready_o (s_aw_ready_o),
    .slv_w_valid_i  (s_w_valid_i),
    .slv_w_i        (s_w_i),
    .slv_w_ready_o  (s_w_ready_o),
    .slv_b_valid_o  (s_b_valid_o),
    .slv_b_o        (s_b_o),
    .slv_b_ready_i  (s_b_ready_i),
    .slv_ar_valid_i (s_ar_valid_i),
    .slv_ar_i       (s_ar_i),
    .slv_ar_ready_o (s_ar_ready_o),
    .slv_r_valid_o  (s_r_valid_o),
    .slv_r_o        (s_r_o),
    .slv_r_ready_i  (s_r_ready_i),
    .bus_o          (mem_bus.mst)
  );

  // The write engine owns AW, W and B of the shared bus; the read engine owns AR and R.
  axi_mem_write u_wr (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus_i  (mem_bus.slv),
    .mem_o  (wr_port.client)
  );

  axi_mem_read u_rd (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus_i  (mem_bus.slv),
    .mem_o  (rd_port.client)
  );

  shared_sram u_sram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .wr_i   (wr_port.server),
    .rd_i   (rd_port.server)
  );

endmodule

`default_nettype wire

// File: sim/tb_atop_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_mini_defs.svh"

// Directed testbench for the memory target behind the ATOP filter.
// Inputs change 1 ns after a rising edge and outputs are sampled on the falling edge.
module tb_atop_mem_top;

  // Cycles that one handshake may take before it counts as hung.
  localparam int HS_LIMIT = 64;
  // Beats of all tests, where each AW, AR and B counts as one beat.
  localparam int TOTAL_BEATS = 11 + 9 + 21 + 11 + 5;
  // Byte address of the burst that the first test writes.
  localparam logic [15:0] ADDR_A = 16'h0040;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   s_aw_valid_i;
  axi_mini_pkg::aw_chan_t s_aw_i;
  logic                   s_aw_ready_o;
  logic                   s_w_valid_i;
  axi_mini_pkg::w_chan_t  s_w_i;
  logic                   s_w_ready_o;
  logic                   s_b_valid_o;
  axi_mini_pkg::b_chan_t  s_b_o;
  logic                   s_b_ready_i;
  logic                   s_ar_valid_i;
  axi_mini_pkg::ar_chan_t s_ar_i;
  logic                   s_ar_ready_o;
  logic                   s_r_valid_o;
  axi_mini_pkg::r_chan_t  s_r_o;
  logic                   s_r_ready_i;

  logic [31:0]            lfsr_q = 32'h40c2;
  // Model of the memory contents, one entry per word.
  axi_mini_pkg::data_t    model_mem [`MEM_DEPTH];
  int                     mismatches = 0;
  int                     timeouts = 0;

  atop_mem_top uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .s_aw_valid_i (s_aw_valid_i),
    .s_aw_i       (s_aw_i),
    .s_aw_ready_o (s_aw_ready_o),
    .s_w_valid_i  (s_w_valid_i),
    .s_w_i        (s_w_i),
    .s_w_ready_o  (s_w_ready_o),
    .s_b_valid_o  (s_b_valid_o),
    .s_b_o        (s_b_o),
    .s_b_ready_i  (s_b_ready_i),
    .s_ar_valid_i (s_ar_valid_i),
    .s_ar_i       (s_ar_i),
    .s_ar_ready_o (s_ar_ready_o),
    .s_r_valid_o  (s_r_valid_o),
    .s_r_o        (s_r_o),
    .s_r_ready_i  (s_r_ready_i)
  );

  // 100 ns clock period.
  always #50 clk_i = ~clk_i;

  // Fibonacci LFSR with taps 32, 22, 2 and 1. Every call takes one new bit.
  function automatic logic rand_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic axi_mini_pkg::data_t rand_word();
    axi_mini_pkg::data_t w;
    w = '0;
    for (int i = 0; i < `AXI_DATA_W; i++) begin
      w = {w[`AXI_DATA_W-2:0], rand_bit()};
    end
    return w;
  endfunction

  // Word index of one beat; bursts wrap at the end of the memory.
  function automatic logic [`MEM_ADDR_W-1:0] word_idx(input axi_mini_pkg::addr_t addr,
                                                     input int beat);
    return addr[`MEM_ADDR_W+1:2] + `MEM_ADDR_W'(beat);
  endfunction

  // One R beat as text for a mismatch line.
  function automatic string format_r(input axi_mini_pkg::r_chan_t r);
    return $sformatf("id=%h data=%h resp=%h last=%b", r.id, r.data, r.resp, r.last);
  endfunction

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_b(input string name, input axi_mini_pkg::b_chan_t exp,
                         input axi_mini_pkg::b_chan_t act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s expected id=%h resp=%h, got id=%h resp=%h",
               $time, name, exp.id, exp.resp, act.id, act.resp);
    end
  endtask

  task automatic check_r(input string name, input axi_mini_pkg::r_chan_t exp,
                         input axi_mini_pkg::r_chan_t act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s expected %s, got %s", $time, name, format_r(exp),
               format_r(act));
    end
  endtask

  task automatic report_timeout(input string chan);
    timeouts++;
    $display("Timeout at %0t: no %s handshake within %0d cycles", $time, chan, HS_LIMIT);
  endtask

  // All send and receive tasks start and end 1 ns after a rising edge.
  task automatic send_aw(input axi_mini_pkg::aw_chan_t aw);
    int n;
    s_aw_i = aw;
    s_aw_valid_i = 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!s_aw_ready_o && n < HS_LIMIT);
    if (!s_aw_ready_o) begin
      report_timeout("AW");
    end
    @(posedge clk_i);
    #1;
    s_aw_valid_i = 1'b0;
  endtask

  task automatic send_w(input axi_mini_pkg::data_t data, input logic last);
    int n;
    s_w_i.data = data;
    s_w_i.last = last;
    s_w_valid_i = 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!s_w_ready_o && n < HS_LIMIT);
    if (!s_w_ready_o) begin
      report_timeout("W");
    end
    @(posedge clk_i);
    #1;
    s_w_valid_i = 1'b0;
  endtask

  task automatic send_ar(input axi_mini_pkg::ar_chan_t ar);
    int n;
    s_ar_i = ar;
    s_ar_valid_i = 1'b1;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!s_ar_ready_o && n < HS_LIMIT);
    if (!s_ar_ready_o) begin
      report_timeout("AR");
    end
    @(posedge clk_i);
    #1;
    s_ar_valid_i = 1'b0;
  endtask

  // With stall set, ready follows one LFSR bit per cycle.
  task automatic recv_b(input axi_mini_pkg::b_chan_t exp, input bit stall);
    bit done;
    int n;
    done = 1'b0;
    n = 0;
    while (!done && n < HS_LIMIT) begin
      s_b_ready_i = stall ? rand_bit() : 1'b1;
      @(negedge clk_i);
      if (s_b_valid_o && s_b_ready_i) begin
        check_b("s_b_o", exp, s_b_o);
        done = 1'b1;
      end
      n++;
      @(posedge clk_i);
      #1;
    end
    s_b_ready_i = 1'b0;
    if (!done) begin
      report_timeout("B");
    end
  endtask

  task automatic recv_r(input axi_mini_pkg::r_chan_t exp, input bit stall);
    axi_mini_pkg::r_chan_t held;
    bit                    done;
    bit                    stalled;
    int                    n;
    done = 1'b0;
    stalled = 1'b0;
    held = '0;
    n = 0;
    while (!done && n < HS_LIMIT) begin
      s_r_ready_i = stall ? rand_bit() : 1'b1;
      @(negedge clk_i);
      // A beat offered without ready last cycle must still be there unchanged.
      if (stalled) begin
        check_flag("s_r_valid_o while stalled", 1'b1, s_r_valid_o);
        check_r("s_r_o while stalled", held, s_r_o);
      end
      stalled = s_r_valid_o && !s_r_ready_i;
      held = s_r_o;
      if (s_r_valid_o && s_r_ready_i) begin
        check_r("s_r_o", exp, s_r_o);
        done = 1'b1;
      end
      n++;
      @(posedge clk_i);
      #1;
    end
    s_r_ready_i = 1'b0;
    if (!done) begin
      report_timeout("R");
    end
  endtask

  // No ready and no response may show while nothing is requested.
  task automatic expect_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_flag("s_aw_ready_o", 1'b0, s_aw_ready_o);
      check_flag("s_w_ready_o", 1'b0, s_w_ready_o);
      check_flag("s_b_valid_o", 1'b0, s_b_valid_o);
      check_flag("s_ar_ready_o", 1'b0, s_ar_ready_o);
      check_flag("s_r_valid_o", 1'b0, s_r_valid_o);
    end
    @(posedge clk_i);
    #1;
  endtask

  // A plain burst with fresh LFSR data. The model takes the data right away.
  task automatic write_burst(input axi_mini_pkg::id_t id, input axi_mini_pkg::addr_t addr,
                             input axi_mini_pkg::len_t len, input bit stall);
    axi_mini_pkg::aw_chan_t aw;
    axi_mini_pkg::b_chan_t  exp_b;
    axi_mini_pkg::data_t    data [$];
    aw = '{id: id, addr: addr, len: len, atop: 6'h00};
    exp_b = '{id: id, resp: axi_mini_pkg::RESP_OKAY};
    for (int i = 0; i <= int'(len); i++) begin
      data.push_back(rand_word());
      model_mem[word_idx(addr, i)] = data[i];
    end
    fork
      send_aw(aw);
      begin
        for (int i = 0; i <= int'(len); i++) begin
          send_w(data[i], i == int'(len));
        end
      end
      recv_b(exp_b, stall);
    join
  endtask

  task automatic read_check(input axi_mini_pkg::id_t id, input axi_mini_pkg::addr_t addr,
                            input axi_mini_pkg::len_t len, input bit stall);
    axi_mini_pkg::ar_chan_t ar;
    axi_mini_pkg::r_chan_t  exp_r;
    ar = '{id: id, addr: addr, len: len};
    fork
      send_ar(ar);
      begin
        for (int i = 0; i <= int'(len); i++) begin
          exp_r = '{id: id, data: model_mem[word_idx(addr, i)],
                    resp: axi_mini_pkg::RESP_OKAY, last: (i == int'(len))};
          recv_r(exp_r, stall);
        end
      end
    join
  endtask

  // An atomic burst gets a SLVERR B. Every kind but atomic store also gets len+1
  // SLVERR R beats with zero data, and the model memory stays as it is.
  task automatic atomic_check(input axi_mini_pkg::id_t id, input axi_mini_pkg::addr_t addr,
                              input axi_mini_pkg::len_t len,
                              input axi_mini_pkg::atop_kind_e kind);
    axi_mini_pkg::aw_chan_t aw;
    axi_mini_pkg::b_chan_t  exp_b;
    axi_mini_pkg::r_chan_t  exp_r;
    aw = '{id: id, addr: addr, len: len, atop: {kind, 4'h0}};
    exp_b = '{id: id, resp: axi_mini_pkg::RESP_SLVERR};
    fork
      send_aw(aw);
      begin
        for (int i = 0; i <= int'(len); i++) begin
          send_w(rand_word(), i == int'(len));
        end
      end
      recv_b(exp_b, 1'b0);
      if (kind != axi_mini_pkg::ATOP_ATOMICSTORE) begin
        for (int i = 0; i <= int'(len); i++) begin
          exp_r = '{id: id, data: '0, resp: axi_mini_pkg::RESP_SLVERR,
                    last: (i == int'(len))};
          recv_r(exp_r, 1'b0);
        end
      end
    join
    if (kind == axi_mini_pkg::ATOP_ATOMICSTORE) begin
      expect_idle(4);
    end
  endtask

  task automatic test_reset_state();
    rst_ni = 1'b0;
    expect_idle(2);
    rst_ni = 1'b1;
    expect_idle(4);
  endtask

  task automatic test_write_read();
    write_burst(4'h3, ADDR_A, 8'd3, 1'b0);
    read_check(4'h9, ADDR_A, 8'd3, 1'b0);
  endtask

  task automatic test_atomic_store();
    atomic_check(4'h1, ADDR_A, 8'd1, axi_mini_pkg::ATOP_ATOMICSTORE);
    read_check(4'h2, ADDR_A, 8'd3, 1'b0);
  endtask

  task automatic test_atomic_load_swap();
    atomic_check(4'ha, ADDR_A, 8'd2, axi_mini_pkg::ATOP_ATOMICLOAD);
    atomic_check(4'hb, ADDR_A, 8'd2, axi_mini_pkg::ATOP_ATOMICSWAP_CMP);
    read_check(4'hc, ADDR_A, 8'd3, 1'b0);
  endtask

  // Both engines compete for the SRAM while the responses are back-pressured.
  task automatic test_contention();
    fork
      write_burst(4'h5, 16'h0100, 8'd3, 1'b1);
      read_check(4'h6, ADDR_A, 8'd3, 1'b1);
    join
    read_check(4'h7, 16'h0100, 8'd3, 1'b0);
  endtask

  initial begin
    rst_ni       = 1'b0;
    s_aw_valid_i = 1'b0;
    s_aw_i       = '0;
    s_w_valid_i  = 1'b0;
    s_w_i        = '0;
    s_b_ready_i  = 1'b0;
    s_ar_valid_i = 1'b0;
    s_ar_i       = '0;
    s_r_ready_i  = 1'b0;
    test_reset_state();
    test_write_read();
    test_atomic_store();
    test_atomic_load_swap();
    test_contention();
    expect_idle(2);
    $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Ends a hung run; every beat gets 20 cycles.
  initial begin
    repeat (TOTAL_BEATS * 20) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles", TOTAL_BEATS * 20);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: atop_mem_top.f
+incdir+rtl
rtl/axi_mini_pkg.sv
rtl/mem_pkg.sv
rtl/axi_chan_if.sv
rtl/mem_port_if.sv
rtl/axi_atop_filter.sv
rtl/axi_mem_write.sv
rtl/axi_mem_read.sv
rtl/shared_sram.sv
rtl/atop_mem_top.sv
sim/tb_atop_mem_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_atop_mem_top
RTL_TOP   ?= atop_mem_top
FILELIST  ?= atop_mem_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
